// File: fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit
  import isa_pkg::*, pipe_pkg::*;
#(
  parameter addr_t RESET_PC    = 32'h0000_0000,
  parameter addr_t TRAP_VECTOR = 32'h0000_0100
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        stall_i,
  output addr_t       imem_addr_o,
  input  logic [31:0] imem_rdata_i,
  input  logic        imem_ready_i,
  input  logic        jump_i,
  input  logic        trap_i,
  input  addr_t       jump_target_i,
  output pipe_token_t token_o
);

  addr_t pc_q;

  // next pc, trap beats jump beats stall
  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q <= RESET_PC;
    end else if (trap_i) begin
      pc_q <= TRAP_VECTOR;
    end else if (jump_i) begin
      pc_q <= jump_target_i;
    end else if (!stall_i) begin
      // sequential fetch
      pc_q <= pc_q + 32'd4;
    end
  end

  // address goes out straight from the pc register
  assign imem_addr_o = pc_q;

  // IF token built from the same-cycle read data
  always_comb begin
    token_o.valid = imem_ready_i;
    token_o.pc    = pc_q;
    token_o.instr = isa_word_u'(imem_rdata_i);
  end

endmodule

// File: hazard_detect.sv
`timescale 1ns/1ps

module hazard_detect
  import isa_pkg::*, pipe_pkg::*;
#(
  parameter int MULDIV_CYCLES = 3
) (
  input  logic           clk,
  input  logic           rst,
  input  pipe_token_t    id_tok_i,
  input  pipe_token_t    ex_tok_i,
  input  pipe_token_t    mem_tok_i,
  input  pipe_token_t    wb_tok_i,
  input  logic           imem_ready_i,
  input  logic           dmem_ready_i,
  output logic           dmem_req_o,
  output addr_t          jump_target_o,
  hazard_req_if.detector req
);

  localparam int CNT_W = $clog2(MULDIV_CYCLES + 1);

  isa_word_u id_w;
  isa_word_u ex_w;
  isa_word_u mem_w;
  logic [CNT_W-1:0] md_cnt;
  logic ex_load;
  logic ex_muldiv;
  logic mem_ls;
  logic id_rs2_used;
  logic rs_match;
  logic trap_c;
  logic jump_c;
  logic md_busy;
  logic md_leave;
  logic mem_wait_c;
  logic load_use_c;

  assign id_w  = id_tok_i.instr;
  assign ex_w  = ex_tok_i.instr;
  assign mem_w = mem_tok_i.instr;

  // ecall at WB, everything younger gets flushed
  assign trap_c = wb_tok_i.valid && is_ecall(wb_tok_i.instr);

  // jump resolves in EX
  assign jump_c = ex_tok_i.valid && (ex_w.i.opcode == OPC_JUMP);
  // target is pc + sext(imm12) << 1
  assign jump_target_o = ex_tok_i.pc + {{19{ex_w.i.imm12[11]}}, ex_w.i.imm12, 1'b0};

  // load/store in MEM, killed if an ecall ahead of it traps
  assign mem_ls     = mem_tok_i.valid &&
                      ((mem_w.i.opcode == OPC_LOAD) || (mem_w.r.opcode == OPC_STORE));
  assign dmem_req_o = mem_ls && !trap_c;
  assign mem_wait_c = dmem_req_o && !dmem_ready_i;

  // load-use, rs2 only counts for register ops and stores
  assign ex_load     = ex_tok_i.valid && (ex_w.i.opcode == OPC_LOAD) && (ex_w.i.rd != '0);
  assign id_rs2_used = (id_w.r.opcode == OPC_OP) || (id_w.r.opcode == OPC_STORE);
  assign rs_match    = (id_w.r.rs1 == ex_w.i.rd) ||
                       (id_rs2_used && (id_w.r.rs2 == ex_w.i.rd));
  assign load_use_c  = ex_load && id_tok_i.valid && rs_match;

  // mul/div holds EX until the counter hits MULDIV_CYCLES-1
  assign ex_muldiv = ex_tok_i.valid && is_muldiv(ex_w);
  assign md_busy   = ex_muldiv && (md_cnt != CNT_W'(MULDIV_CYCLES - 1));
  // op moves on once nothing holds EX, or dies on trap
  assign md_leave  = trap_c || (!md_busy && !mem_wait_c);

  always_ff @(posedge clk) begin
    if (rst) begin
      md_cnt <= '0;
    end else if (!ex_muldiv || md_leave) begin
      md_cnt <= '0;
    end else if (md_busy) begin
      md_cnt <= md_cnt + CNT_W'(1);
    end
  end

  assign req.mem_wait = mem_wait_c;
  assign req.trap     = trap_c;
  assign req.jump     = jump_c;
  assign req.muldiv   = md_busy;
  assign req.load_use = load_use_c;
  // imem wait only when no other request already owns PC and IF/ID
  assign req.if_wait  = !imem_ready_i && !(trap_c || jump_c || md_busy || load_use_c);

endmodule

// File: hazard_pipe_top.sv
`timescale 1ns/1ps

module hazard_pipe_top
  import isa_pkg::*, pipe_pkg::*;
#(
  parameter addr_t RESET_PC      = 32'h0000_0000,
  parameter addr_t TRAP_VECTOR   = 32'h0000_0100,
  parameter int    MULDIV_CYCLES = 3
) (
  input  logic        clk,
  input  logic        rst,
  output addr_t       imem_addr_o,
  input  logic [31:0] imem_rdata_i,
  input  logic        imem_ready_i,
  output logic        dmem_req_o,
  input  logic        dmem_ready_i,
  output logic        retire_valid_o,
  output addr_t       retire_pc_o,
  output isa_word_u   retire_instr_o,
  output logic        trap_o,
  output logic [31:0] retire_count_o
);

  // index 0 is the IF token, k is the output of stage register k
  pipe_token_t stage_tok [NUM_STAGE_REGS+1];
  ctrl_vec_t   stall;
  ctrl_vec_t   flush;
  addr_t       jump_target;
  logic        redirect_jump;
  logic        redirect_trap;

  hazard_req_if hreq ();

  // redirect only when the encoder picked that request
  assign redirect_trap = hreq.trap && flush[STG_MEMWB] && flush[STG_IFID];
  assign redirect_jump = hreq.jump && flush[STG_IDEX] && !flush[STG_MEMWB];

  fetch_unit #(
    .RESET_PC    (RESET_PC),
    .TRAP_VECTOR (TRAP_VECTOR)
  ) u_fetch (
    .clk           (clk),
    .rst           (rst),
    .stall_i       (stall[STG_PC]),
    .imem_addr_o   (imem_addr_o),
    .imem_rdata_i  (imem_rdata_i),
    .imem_ready_i  (imem_ready_i),
    .jump_i        (redirect_jump),
    .trap_i        (redirect_trap),
    .jump_target_i (jump_target),
    .token_o       (stage_tok[0])
  );

  // IF/ID, ID/EX, EX/MEM, MEM/WB
  for (genvar i = 0; i < NUM_STAGE_REGS; i++) begin : g_stage
    stage_reg u_stage (
      .clk     (clk),
      .rst     (rst),
      .stall_i (stall[STG_IFID+i]),
      .flush_i (flush[STG_IFID+i]),
      .token_i (stage_tok[i]),
      .token_o (stage_tok[i+1])
    );
  end

  hazard_detect #(
    .MULDIV_CYCLES (MULDIV_CYCLES)
  ) u_detect (
    .clk           (clk),
    .rst           (rst),
    .id_tok_i      (stage_tok[STG_IFID]),
    .ex_tok_i      (stage_tok[STG_IDEX]),
    .mem_tok_i     (stage_tok[STG_EXMEM]),
    .wb_tok_i      (stage_tok[STG_MEMWB]),
    .imem_ready_i  (imem_ready_i),
    .dmem_ready_i  (dmem_ready_i),
    .dmem_req_o    (dmem_req_o),
    .jump_target_o (jump_target),
    .req           (hreq.detector)
  );

  pipeline_control u_ctrl (
    .req     (hreq.control),
    .stall_o (stall),
    .flush_o (flush)
  );

  retire_unit u_retire (
    .clk            (clk),
    .rst            (rst),
    .stall_i        (stall[STG_RET]),
    .flush_i        (flush[STG_RET]),
    .token_i        (stage_tok[NUM_STAGE_REGS]),
    .retire_valid_o (retire_valid_o),
    .retire_pc_o    (retire_pc_o),
    .retire_instr_o (retire_instr_o),
    .trap_o         (trap_o),
    .retire_count_o (retire_count_o)
  );

endmodule

// File: hazard_req_if.sv
`timescale 1ns/1ps

// hazard request strobes, plain levels valid within the cycle
interface hazard_req_if;

  // dmem not ready with a load/store in MEM
  logic mem_wait;
  // imem not ready at fetch
  logic if_wait;
  // ecall reached WB
  logic trap;
  // jump resolved in EX
  logic jump;
  // mul/div still busy in EX
  logic muldiv;
  // load in EX feeds the op in ID
  logic load_use;

  modport detector (
    output mem_wait, if_wait, trap, jump, muldiv, load_use
  );

  modport control (
    input mem_wait, if_wait, trap, jump, muldiv, load_use
  );

endinterface

// File: isa_pkg.sv
package isa_pkg;

  typedef logic [4:0] reg_idx_t;

  // major opcodes, low 7 bits of the word
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_JUMP   = 7'b1101111;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  // funct7 value that turns a register op into mul/div
  localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

  // register-register view
  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    logic [6:0] opcode;
  } isa_r_t;

  // immediate view, also used by jump and system
  typedef struct packed {
    logic [11:0] imm12;
    reg_idx_t    rs1;
    logic [2:0]  funct3;
    reg_idx_t    rd;
    logic [6:0]  opcode;
  } isa_i_t;

  typedef union packed {
    isa_r_t r;
    isa_i_t i;
  } isa_word_u;

  // ecall is a system op with a zero immediate
  function automatic logic is_ecall(isa_word_u w);
    return (w.i.opcode == OPC_SYSTEM) && (w.i.imm12 == 12'd0);
  endfunction

  function automatic logic is_muldiv(isa_word_u w);
    return (w.r.opcode == OPC_OP) && (w.r.funct7 == FUNCT7_MULDIV);
  endfunction

endpackage

// File: pipe_pkg.sv
package pipe_pkg;
  import isa_pkg::*;

  // generated registers IF/ID, ID/EX, EX/MEM, MEM/WB
  localparam int NUM_STAGE_REGS = 4;
  // plus PC below and retire above
  localparam int NUM_CTRL_BITS = NUM_STAGE_REGS + 2;

  // bit positions inside a stall or flush vector
  localparam int STG_PC    = 0;
  localparam int STG_IFID  = 1;
  localparam int STG_IDEX  = 2;
  localparam int STG_EXMEM = 3;
  localparam int STG_MEMWB = 4;
  localparam int STG_RET   = 5;

  typedef logic [31:0] addr_t;

  typedef logic [NUM_CTRL_BITS-1:0] ctrl_vec_t;

  // one instruction in flight, 65 bits
  typedef struct packed {
    logic      valid;
    addr_t     pc;
    isa_word_u instr;
  } pipe_token_t;

endpackage

// File: pipeline_control.sv
`timescale 1ns/1ps

module pipeline_control
  import pipe_pkg::*;
(
  hazard_req_if.control req,
  output ctrl_vec_t     stall_o,
  output ctrl_vec_t     flush_o
);

  // bit order: retire, MEM/WB, EX/MEM, ID/EX, IF/ID, PC
  localparam ctrl_vec_t MEM_WAIT_STALL = 6'b001111;
  localparam ctrl_vec_t MEM_WAIT_FLUSH = 6'b010000;
  localparam ctrl_vec_t IF_WAIT_STALL  = 6'b000001;
  localparam ctrl_vec_t IF_WAIT_FLUSH  = 6'b000010;
  localparam ctrl_vec_t TRAP_STALL     = 6'b000000;
  localparam ctrl_vec_t TRAP_FLUSH     = 6'b011110;
  localparam ctrl_vec_t JUMP_STALL     = 6'b000010;
  localparam ctrl_vec_t JUMP_FLUSH     = 6'b000110;
  localparam ctrl_vec_t MULDIV_STALL   = 6'b000111;
  localparam ctrl_vec_t MULDIV_FLUSH   = 6'b001000;
  localparam ctrl_vec_t LOAD_USE_STALL = 6'b000011;
  localparam ctrl_vec_t LOAD_USE_FLUSH = 6'b000100;

  // later stage ranks higher
  always_comb begin
    if (req.mem_wait) begin
      // freeze up to EX/MEM, bubble into MEM/WB
      stall_o = MEM_WAIT_STALL;
      flush_o = MEM_WAIT_FLUSH;
    end else if (req.if_wait) begin
      stall_o = IF_WAIT_STALL;
      flush_o = IF_WAIT_FLUSH;
    end else if (req.trap) begin
      // drop all younger ops, ecall itself retires
      stall_o = TRAP_STALL;
      flush_o = TRAP_FLUSH;
    end else if (req.jump) begin
      // two wrong-path slots
      stall_o = JUMP_STALL;
      flush_o = JUMP_FLUSH;
    end else if (req.muldiv) begin
      stall_o = MULDIV_STALL;
      flush_o = MULDIV_FLUSH;
    end else if (req.load_use) begin
      // one bubble into EX
      stall_o = LOAD_USE_STALL;
      flush_o = LOAD_USE_FLUSH;
    end else begin
      stall_o = '0;
      flush_o = '0;
    end
  end

endmodule

// File: retire_unit.sv
`timescale 1ns/1ps

module retire_unit
  import isa_pkg::*, pipe_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        stall_i,
  input  logic        flush_i,
  input  pipe_token_t token_i,
  output logic        retire_valid_o,
  output addr_t       retire_pc_o,
  output isa_word_u   retire_instr_o,
  output logic        trap_o,
  output logic [31:0] retire_count_o
);

  pipe_token_t ret_tok;

  // retire register behaves like any other stage
  stage_reg u_ret_reg (
    .clk     (clk),
    .rst     (rst),
    .stall_i (stall_i),
    .flush_i (flush_i),
    .token_i (token_i),
    .token_o (ret_tok)
  );

  assign retire_valid_o = ret_tok.valid;
  assign retire_pc_o    = ret_tok.pc;
  assign retire_instr_o = ret_tok.instr;
  assign trap_o         = ret_tok.valid && is_ecall(ret_tok.instr);

  // count on capture so it moves with retire_valid_o
  always_ff @(posedge clk) begin
    if (rst) begin
      retire_count_o <= '0;
    end else if (token_i.valid && !stall_i && !flush_i) begin
      retire_count_o <= retire_count_o + 32'd1;
    end
  end

endmodule

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f sim.f --top-module tb_hazard_pipe -o tb_sim
out=$(./obj_dir/tb_sim)
echo "$out"
echo "$out" | grep -q '^>>> PASS$'

// File: sim.f
isa_pkg.sv
pipe_pkg.sv
hazard_req_if.sv
fetch_unit.sv
stage_reg.sv
hazard_detect.sv
pipeline_control.sv
retire_unit.sv
hazard_pipe_top.sv
tb_hazard_pipe.sv

// File: stage_reg.sv
`timescale 1ns/1ps

module stage_reg
  import isa_pkg::*, pipe_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        stall_i,
  input  logic        flush_i,
  input  pipe_token_t token_i,
  output pipe_token_t token_o
);

  logic      valid_q;
  addr_t     pc_q;
  isa_word_u instr_q;

  // flush turns the slot into a bubble, even when stalled
  always_ff @(posedge clk) begin
    if (rst || flush_i) begin
      valid_q <= 1'b0;
    end else if (!stall_i) begin
      valid_q <= token_i.valid;
    end
  end

  // payload only follows the hold
  always_ff @(posedge clk) begin
    if (!stall_i) begin
      pc_q    <= token_i.pc;
      instr_q <= token_i.instr;
    end
  end

  assign token_o = '{valid: valid_q, pc: pc_q, instr: instr_q};

endmodule

// File: tb_hazard_pipe.sv
`timescale 1ns/1ps

module tb_hazard_pipe
  import isa_pkg::*, pipe_pkg::*;
();

  localparam addr_t RESET_PC      = 32'h0000_0000;
  localparam addr_t TRAP_VECTOR   = 32'h0000_0100;
  localparam int    MULDIV_CYCLES = 3;
  localparam int    MAX_RET       = 64;

  // end marker is a plain op writing x0 with funct3 set
  localparam isa_word_u END_WORD = isa_word_u'({17'd0, 3'b111, 5'd0, OPC_OP});

  logic        clk;
  logic        rst;
  addr_t       imem_addr;
  logic [31:0] imem_rdata;
  logic        imem_ready;
  logic        dmem_req;
  logic        dmem_ready;
  logic        retire_valid;
  addr_t       retire_pc;
  isa_word_u   retire_instr;
  logic        trap;
  logic [31:0] retire_count;

  isa_word_u   prog_mem [0:127];
  addr_t       exp_pc [0:MAX_RET-1];
  isa_word_u   exp_ins [0:MAX_RET-1];
  int          ret_cyc [0:MAX_RET-1];
  int          n_exp;
  int          cyc;
  int          clk_cnt;
  int          limit;
  int          val_errs;
  int          other_errs;
  logic [15:0] lfsr_q;

  hazard_pipe_top #(
    .RESET_PC      (RESET_PC),
    .TRAP_VECTOR   (TRAP_VECTOR),
    .MULDIV_CYCLES (MULDIV_CYCLES)
  ) u_dut (
    .clk            (clk),
    .rst            (rst),
    .imem_addr_o    (imem_addr),
    .imem_rdata_i   (imem_rdata),
    .imem_ready_i   (imem_ready),
    .dmem_req_o     (dmem_req),
    .dmem_ready_i   (dmem_ready),
    .retire_valid_o (retire_valid),
    .retire_pc_o    (retire_pc),
    .retire_instr_o (retire_instr),
    .trap_o         (trap),
    .retire_count_o (retire_count)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // instruction memory, same-cycle read, filler outside the array
  always_comb begin
    if (imem_addr[31:9] == 23'd0) begin
      imem_rdata = prog_mem[imem_addr[8:2]];
    end else begin
      imem_rdata = filler_at(imem_addr);
    end
  end

  // run limit
  always @(posedge clk) begin
    clk_cnt <= clk_cnt + 1;
    if (limit != 0 && clk_cnt > limit) begin
      $display("timeout: pipeline stopped retiring after %0d cycles", clk_cnt);
      $display(">>> FAIL");
      $finish;
    end
  end

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic lsb;
    lsb = s[0];
    s = s >> 1;
    if (lsb) begin
      s = s ^ 16'hB400;
    end
    return s;
  endfunction

  task automatic rand_bit(output logic b);
    b = lfsr_q[0];
    lfsr_q = lfsr_next(lfsr_q);
  endtask

  // plain op writing x0 and reading nothing
  // funct7 msb keeps it apart from mul/div and the end marker
  function automatic isa_word_u filler_at(addr_t a);
    logic [8:0] fold;
    fold = a[10:2] ^ a[19:11] ^ a[28:20] ^ {4'd0, a[1:0], a[31:29]};
    return isa_word_u'({1'b1, fold[5:0], 10'd0, fold[8:6], 5'd0, OPC_OP});
  endfunction

  // instruction builders
  function automatic isa_word_u mk_op(reg_idx_t rd, reg_idx_t rs1, reg_idx_t rs2,
                                      logic [6:0] f7);
    return isa_word_u'({f7, rs2, rs1, 3'b000, rd, OPC_OP});
  endfunction

  function automatic isa_word_u mk_load(reg_idx_t rd, reg_idx_t rs1);
    return isa_word_u'({12'd0, rs1, 3'b010, rd, OPC_LOAD});
  endfunction

  function automatic isa_word_u mk_store(reg_idx_t rs1, reg_idx_t rs2);
    return isa_word_u'({7'd0, rs2, rs1, 3'b010, 5'd0, OPC_STORE});
  endfunction

  function automatic isa_word_u mk_jump(logic [11:0] imm);
    return isa_word_u'({imm, 5'd0, 3'b000, 5'd0, OPC_JUMP});
  endfunction

  function automatic isa_word_u mk_ecall();
    return isa_word_u'({12'd0, 13'd0, OPC_SYSTEM});
  endfunction

  function automatic logic ecall_word(isa_word_u w);
    return (w.i.opcode == OPC_SYSTEM) && (w.i.imm12 == 12'd0);
  endfunction

  function automatic isa_word_u word_at(addr_t a);
    if (a[31:9] != 23'd0) begin
      return filler_at(a);
    end
    return prog_mem[a[8:2]];
  endfunction

  task automatic check_addr(string name, addr_t got, addr_t exp);
    if (got !== exp) begin
      $display("error %s got %h expected %h", name, got, exp);
      val_errs++;
    end
  endtask

  task automatic check_word(string name, isa_word_u got, isa_word_u exp);
    if (got !== exp) begin
      $display("error %s got %h expected %h", name, got, exp);
      val_errs++;
    end
  endtask

  task automatic check_flag(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      $display("error %s got %h expected %h", name, got, exp);
      val_errs++;
    end
  endtask

  task automatic fail_msg(string what);
    $display("failure: %s", what);
    other_errs++;
  endtask

  task automatic build_prog(int id);
    for (int k = 0; k < 128; k++) begin
      prog_mem[k] = filler_at(addr_t'(k * 4));
    end
    case (id)
      // straight line, no dependencies
      2: begin
        for (int k = 0; k < 6; k++) begin
          prog_mem[k] = mk_op(reg_idx_t'(10 + k), 5'd1, 5'd2, 7'd0);
        end
        prog_mem[6] = END_WORD;
      end
      // load-use then mul/div
      3: begin
        prog_mem[0] = mk_load(5'd5, 5'd1);
        prog_mem[1] = mk_op(5'd6, 5'd5, 5'd2, 7'd0);
        prog_mem[2] = mk_op(5'd7, 5'd3, 5'd4, FUNCT7_MULDIV);
        prog_mem[3] = mk_op(5'd8, 5'd1, 5'd2, 7'd0);
        prog_mem[4] = mk_store(5'd1, 5'd6);
        prog_mem[5] = END_WORD;
      end
      // jump from 0x04 to 0x14
      4: begin
        prog_mem[0] = mk_op(5'd10, 5'd1, 5'd2, 7'd0);
        prog_mem[1] = mk_jump(12'd8);
        prog_mem[2] = mk_op(5'd11, 5'd1, 5'd2, 7'd0);
        prog_mem[3] = mk_op(5'd12, 5'd1, 5'd2, 7'd0);
        prog_mem[4] = mk_op(5'd13, 5'd1, 5'd2, 7'd0);
        prog_mem[5] = mk_op(5'd14, 5'd1, 5'd2, 7'd0);
        prog_mem[6] = END_WORD;
      end
      // ecall at 0x04, handler at trap vector
      5: begin
        prog_mem[0]  = mk_op(5'd10, 5'd1, 5'd2, 7'd0);
        prog_mem[1]  = mk_ecall();
        prog_mem[2]  = mk_op(5'd11, 5'd1, 5'd2, 7'd0);
        prog_mem[3]  = mk_op(5'd12, 5'd1, 5'd2, 7'd0);
        prog_mem[64] = mk_op(5'd13, 5'd1, 5'd2, 7'd0);
        prog_mem[65] = END_WORD;
      end
      // mixed program for back-pressure
      default: begin
        prog_mem[0] = mk_load(5'd5, 5'd1);
        prog_mem[1] = mk_op(5'd6, 5'd5, 5'd2, 7'd0);
        prog_mem[2] = mk_op(5'd7, 5'd3, 5'd4, FUNCT7_MULDIV);
        prog_mem[3] = mk_jump(12'd6);
        prog_mem[4] = mk_op(5'd11, 5'd1, 5'd2, 7'd0);
        prog_mem[5] = mk_op(5'd12, 5'd1, 5'd2, 7'd0);
        prog_mem[6] = mk_store(5'd1, 5'd5);
        prog_mem[7] = mk_load(5'd9, 5'd2);
        prog_mem[8] = mk_op(5'd13, 5'd1, 5'd9, 7'd0);
        prog_mem[9] = END_WORD;
      end
    endcase
  endtask

  // expected retire order by the ISA rules
  task automatic walk_prog();
    addr_t     pc;
    isa_word_u w;
    int        offs;
    pc = RESET_PC;
    n_exp = 0;
    while (n_exp < MAX_RET) begin
      w = word_at(pc);
      if (w == END_WORD) begin
        break;
      end
      exp_pc[n_exp] = pc;
      exp_ins[n_exp] = w;
      n_exp++;
      if (w.i.opcode == OPC_JUMP) begin
        // byte offset is twice the signed immediate
        offs = int'($signed(w.i.imm12)) * 2;
        pc = pc + addr_t'(offs);
      end else if (ecall_word(w)) begin
        pc = TRAP_VECTOR;
      end else begin
        pc = pc + 32'd4;
      end
    end
  endtask

  task automatic step();
    @(posedge clk);
    #10;
    cyc++;
  endtask

  // reset, then check the state right after release
  task automatic reset_dut();
    rst = 1'b1;
    imem_ready = 1'b1;
    dmem_ready = 1'b1;
    repeat (10) step();
    rst = 1'b0;
    check_flag("retire_valid_o", 32'(retire_valid), 32'd0);
    check_flag("trap_o", 32'(trap), 32'd0);
    check_flag("dmem_req_o", 32'(dmem_req), 32'd0);
    check_addr("imem_addr_o", imem_addr, RESET_PC);
  endtask

  task automatic run_prog(int id, logic bp);
    int idx;
    int c0;
    int acc;
    int acc_exp;
    logic b;
    build_prog(id);
    walk_prog();
    // each load and store on the retire path makes one data access
    acc_exp = 0;
    for (int k = 0; k < n_exp; k++) begin
      if (exp_ins[k].i.opcode == OPC_LOAD || exp_ins[k].r.opcode == OPC_STORE) begin
        acc_exp++;
      end
    end
    reset_dut();
    c0 = cyc;
    idx = 0;
    acc = 0;
    while (idx < n_exp) begin
      if (bp) begin
        rand_bit(b);
        imem_ready = b;
        rand_bit(b);
        dmem_ready = b;
      end
      // access completes at the coming edge
      if (dmem_req && dmem_ready) begin
        acc++;
      end
      step();
      if (retire_valid) begin
        ret_cyc[idx] = cyc;
        check_addr("retire_pc_o", retire_pc, exp_pc[idx]);
        check_word("retire_instr_o", retire_instr, exp_ins[idx]);
        check_flag("trap_o", 32'(trap), 32'(ecall_word(exp_ins[idx])));
        check_flag("retire_count_o", retire_count, 32'(idx + 1));
        idx++;
      end
    end
    check_flag("dmem_req_o accesses", 32'(acc), 32'(acc_exp));
    if (id == 2 && ret_cyc[0] - c0 != 5) begin
      fail_msg("first retirement not 5 cycles after the first fetch");
    end
    if (id == 3) begin
      if (ret_cyc[1] - ret_cyc[0] != 2) begin
        fail_msg("load-use did not cost exactly one bubble");
      end
      // mul/div sits in EX for MULDIV_CYCLES and the op behind it follows a cycle later
      if (ret_cyc[2] - ret_cyc[1] != MULDIV_CYCLES) begin
        fail_msg("mul/div did not hold EX for the expected cycles");
      end
      if (ret_cyc[3] - ret_cyc[1] != MULDIV_CYCLES + 1) begin
        fail_msg("op after the mul/div retired at the wrong cycle");
      end
    end
  endtask

  initial begin
    int total;
    rst = 1'b1;
    imem_ready = 1'b1;
    dmem_ready = 1'b1;
    lfsr_q = 16'd53;
    cyc = 0;
    clk_cnt = 0;
    val_errs = 0;
    other_errs = 0;
    limit = 0;
    // size the run limit from all programs
    total = 0;
    for (int id = 2; id <= 6; id++) begin
      build_prog(id);
      walk_prog();
      total += n_exp;
    end
    limit = total * (MULDIV_CYCLES + 8) + 200;
    for (int id = 2; id <= 6; id++) begin
      run_prog(id, id == 6);
    end
    $display("errors: %0d value mismatches, %0d other failures", val_errs, other_errs);
    if (val_errs == 0 && other_errs == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule
